//--- rtl/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// dma data stream
`define PIPE_DATA_W     64
`define PIPE_KEEP_W     (`PIPE_DATA_W / 8)

// control and application words
`define PIPE_CTRL_W     32
`define PIPE_APP_WORDS  5

// function code sits in the low byte of word 0
`define PIPE_FUN_W      8

// status stream
`define PIPE_STS_W      32
`define PIPE_STS_KEEP_W (`PIPE_STS_W / 8)

// accepted word counter reported in status
`define PIPE_CNT_W      8

`endif

//--- rtl/pipe_pkg.sv
`default_nettype none

`include "pipe_config.svh"

package pipe_pkg;

    ////////////////////
    // stream beats
    ////////////////////

    typedef struct packed {
        logic [`PIPE_DATA_W-1:0] tdata;
        logic [`PIPE_KEEP_W-1:0] tkeep;
        logic                    tlast;
    } axis_beat_t;

    typedef struct packed {
        logic [`PIPE_STS_W-1:0]      tdata;
        logic [`PIPE_STS_KEEP_W-1:0] tkeep;
        logic                        tlast;
    } sts_beat_t;

    ////////////////////
    // control words
    ////////////////////

    // any other code selects no channel
    typedef enum logic [`PIPE_FUN_W-1:0] {
        FUN_IMAGE = 8'd0,
        FUN_MATH  = 8'd1,
        FUN_COPY  = 8'd2
    } fun_e;

    // edge detection settings, app word 1 bits 8 to 27
    typedef struct packed {
        logic [7:0] canny_max_val;
        logic [7:0] canny_min_val;
        logic       sobel_edge_sel;
        logic       nonmax_supp_en;
        logic       hyst_threshold_en;
        logic       edge_cut_en;
    } edge_cfg_t;

    typedef logic [`PIPE_APP_WORDS-1:0][`PIPE_CTRL_W-1:0] app_words_t;

    typedef enum logic {
        COLLECT,
        WAIT_STS
    } cap_state_e;

endpackage

`default_nettype wire

//--- rtl/ctrl_word_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module ctrl_word_capture
    import pipe_pkg::*;
(
    input  wire                    aclk,
    input  wire                    arst_n,

    input  wire                    ctrl_tvalid,
    input  wire [`PIPE_CTRL_W-1:0] ctrl_tdata,
    input  wire                    ctrl_tlast,
    output logic                   ctrl_tready,

    output app_words_t             app_words,
    output fun_e                   fun,
    output edge_cfg_t              edge_cfg,
    output logic                   vsync,

    input  wire                    sts_busy,
    output logic                   sts_load,
    output logic [`PIPE_CNT_W-1:0] sts_count
);

    localparam int IDX_W = $clog2(`PIPE_APP_WORDS + 1);

    cap_state_e             state;
    logic [IDX_W-1:0]       widx;
    logic [`PIPE_CNT_W-1:0] cnt;
    logic [`PIPE_CNT_W-1:0] cnt_inc;
    app_words_t             shadow;
    app_words_t             shadow_nxt;
    app_words_t             active;
    logic                   beat_ok;
    logic                   last_ok;

    assign ctrl_tready = (state == COLLECT);
    assign beat_ok     = ctrl_tvalid && ctrl_tready;
    assign last_ok     = beat_ok && ctrl_tlast;

    // counter sticks at all ones on very long packets
    assign cnt_inc = (cnt == '1) ? cnt : cnt + 1'b1;

    // words past index 4 are dropped
    always_comb
    begin
        shadow_nxt = shadow;
        if (beat_ok && widx < IDX_W'(`PIPE_APP_WORDS))
            shadow_nxt[widx] = ctrl_tdata;
    end

    ////////////////////
    // capture fsm
    ////////////////////

    // reset parks in WAIT_STS so tready stays low until the first edge
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= WAIT_STS;
            widx   <= '0;
            cnt    <= '0;
            shadow <= '0;
            active <= '0;
            vsync  <= 1'b0;
        end
        else
        begin
            shadow <= shadow_nxt;
            vsync  <= last_ok;
            case (state)
                COLLECT:
                begin
                    if (last_ok)
                    begin
                        state  <= WAIT_STS;
                        widx   <= '0;
                        cnt    <= '0;
                        active <= shadow_nxt;
                    end
                    else if (beat_ok)
                    begin
                        if (widx < IDX_W'(`PIPE_APP_WORDS))
                            widx <= widx + 1'b1;
                        cnt <= cnt_inc;
                    end
                end
                WAIT_STS:
                begin
                    // hold off the next packet until status is taken
                    if (!sts_busy)
                        state <= COLLECT;
                end
                default:
                    state <= COLLECT;
            endcase
        end
    end

    // status gen samples these on the tlast edge
    assign sts_load  = last_ok;
    assign sts_count = cnt_inc;

    assign app_words = active;
    assign fun       = fun_e'(active[0][`PIPE_FUN_W-1:0]);

    assign edge_cfg.canny_max_val     = active[1][15:8];
    assign edge_cfg.canny_min_val     = active[1][23:16];
    assign edge_cfg.sobel_edge_sel    = active[1][24];
    assign edge_cfg.nonmax_supp_en    = active[1][25];
    assign edge_cfg.hyst_threshold_en = active[1][26];
    assign edge_cfg.edge_cut_en       = active[1][27];

    a_vsync_single: assert property (@(posedge aclk) disable iff (!arst_n)
        vsync |=> !vsync)
        else $error("vsync held for more than one cycle");

    a_wait_blocks_ctrl: assert property (@(posedge aclk) disable iff (!arst_n)
        sts_busy |-> !ctrl_tready)
        else $error("control accepted while status pending");

endmodule

`default_nettype wire

//--- rtl/stream_switch.sv
`timescale 1ns/1ps
`default_nettype none

module stream_switch
    import pipe_pkg::*;
(
    input  fun_e       fun,

    // dma side
    input  wire        mm2s_tvalid,
    input  axis_beat_t mm2s_beat,
    output logic       mm2s_tready,

    output logic       s2mm_tvalid,
    output axis_beat_t s2mm_beat,
    input  wire        s2mm_tready,

    // image channel
    output logic       img_out_tvalid,
    output axis_beat_t img_out_beat,
    input  wire        img_out_tready,
    input  wire        img_in_tvalid,
    input  axis_beat_t img_in_beat,
    output logic       img_in_tready,

    // math channel
    output logic       math_out_tvalid,
    output axis_beat_t math_out_beat,
    input  wire        math_out_tready,
    input  wire        math_in_tvalid,
    input  axis_beat_t math_in_beat,
    output logic       math_in_tready,

    // memory copy channel
    output logic       copy_out_tvalid,
    output axis_beat_t copy_out_beat,
    input  wire        copy_out_tready,
    input  wire        copy_in_tvalid,
    input  axis_beat_t copy_in_beat,
    output logic       copy_in_tready
);

    // idle channels and unknown codes drive zero
    always_comb
    begin
        mm2s_tready     = 1'b0;
        s2mm_tvalid     = 1'b0;
        s2mm_beat       = '0;
        img_out_tvalid  = 1'b0;
        img_out_beat    = '0;
        img_in_tready   = 1'b0;
        math_out_tvalid = 1'b0;
        math_out_beat   = '0;
        math_in_tready  = 1'b0;
        copy_out_tvalid = 1'b0;
        copy_out_beat   = '0;
        copy_in_tready  = 1'b0;

        case (fun)
            FUN_IMAGE:
            begin
                img_out_tvalid = mm2s_tvalid;
                img_out_beat   = mm2s_beat;
                mm2s_tready    = img_out_tready;
                s2mm_tvalid    = img_in_tvalid;
                s2mm_beat      = img_in_beat;
                img_in_tready  = s2mm_tready;
            end
            FUN_MATH:
            begin
                math_out_tvalid = mm2s_tvalid;
                math_out_beat   = mm2s_beat;
                mm2s_tready     = math_out_tready;
                s2mm_tvalid     = math_in_tvalid;
                s2mm_beat       = math_in_beat;
                math_in_tready  = s2mm_tready;
            end
            FUN_COPY:
            begin
                copy_out_tvalid = mm2s_tvalid;
                copy_out_beat   = mm2s_beat;
                mm2s_tready     = copy_out_tready;
                s2mm_tvalid     = copy_in_tvalid;
                s2mm_beat       = copy_in_beat;
                copy_in_tready  = s2mm_tready;
            end
            default:
            begin
            end
        endcase
    end

    // no clock here, so check the outputs as they settle
    always_comb
    begin
        a_one_channel: assert ($onehot0({img_out_tvalid, math_out_tvalid, copy_out_tvalid}))
            else $error("more than one channel output valid");
    end

endmodule

`default_nettype wire

//--- rtl/status_stream_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module status_stream_gen
    import pipe_pkg::*;
(
    input  wire                    aclk,
    input  wire                    arst_n,

    input  wire                    sts_load,
    input  wire [`PIPE_CNT_W-1:0]  sts_count,
    input  fun_e                   fun,

    output logic                   sts_tvalid,
    output sts_beat_t              sts_beat,
    input  wire                    sts_tready,
    output logic                   sts_busy
);

    localparam int PAD_W = `PIPE_STS_W - `PIPE_FUN_W - `PIPE_CNT_W - 1;

    logic                   valid_q;
    logic [`PIPE_CNT_W-1:0] cnt_q;
    logic                   err_q;

    // a new load wins over the handshake
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
            valid_q <= 1'b0;
        else if (sts_load)
            valid_q <= 1'b1;
        else if (sts_tready)
            valid_q <= 1'b0;
    end

    always_ff @(posedge aclk)
    begin
        if (sts_load)
        begin
            cnt_q <= sts_count;
            err_q <= (sts_count != `PIPE_CNT_W'(`PIPE_APP_WORDS));
        end
    end

    // fun switches on the load edge and is frozen while the beat waits
    assign sts_beat.tdata = {{PAD_W{1'b0}}, err_q, cnt_q, fun};
    assign sts_beat.tkeep = '1;
    assign sts_beat.tlast = 1'b1;

    assign sts_tvalid = valid_q;
    assign sts_busy   = valid_q;

    a_sts_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        sts_tvalid && !sts_tready |=> sts_tvalid && $stable(sts_beat))
        else $error("status beat changed while stalled");

endmodule

`default_nettype wire

//--- rtl/pipe_sel.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module pipe_sel
    import pipe_pkg::*;
(
    input  wire                    aclk,
    input  wire                    arst_n,

    // control stream
    input  wire                    ctrl_tvalid,
    input  wire [`PIPE_CTRL_W-1:0] ctrl_tdata,
    input  wire                    ctrl_tlast,
    output logic                   ctrl_tready,

    // dma data
    input  wire                    mm2s_tvalid,
    input  axis_beat_t             mm2s_beat,
    output logic                   mm2s_tready,
    output logic                   s2mm_tvalid,
    output axis_beat_t             s2mm_beat,
    input  wire                    s2mm_tready,

    // processing channels
    output logic                   img_out_tvalid,
    output axis_beat_t             img_out_beat,
    input  wire                    img_out_tready,
    input  wire                    img_in_tvalid,
    input  axis_beat_t             img_in_beat,
    output logic                   img_in_tready,

    output logic                   math_out_tvalid,
    output axis_beat_t             math_out_beat,
    input  wire                    math_out_tready,
    input  wire                    math_in_tvalid,
    input  axis_beat_t             math_in_beat,
    output logic                   math_in_tready,

    output logic                   copy_out_tvalid,
    output axis_beat_t             copy_out_beat,
    input  wire                    copy_out_tready,
    input  wire                    copy_in_tvalid,
    input  axis_beat_t             copy_in_beat,
    output logic                   copy_in_tready,

    // status stream
    output logic                   sts_tvalid,
    output sts_beat_t              sts_beat,
    input  wire                    sts_tready,

    // decoded settings
    output app_words_t             app_words,
    output edge_cfg_t              edge_cfg,
    output logic                   vsync
);

    fun_e                   fun;
    logic                   sts_load;
    logic [`PIPE_CNT_W-1:0] sts_count;
    logic                   sts_busy;

    ctrl_word_capture u_capture (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .ctrl_tvalid (ctrl_tvalid),
        .ctrl_tdata  (ctrl_tdata),
        .ctrl_tlast  (ctrl_tlast),
        .ctrl_tready (ctrl_tready),
        .app_words   (app_words),
        .fun         (fun),
        .edge_cfg    (edge_cfg),
        .vsync       (vsync),
        .sts_busy    (sts_busy),
        .sts_load    (sts_load),
        .sts_count   (sts_count)
    );

    stream_switch u_switch (
        .fun             (fun),
        .mm2s_tvalid     (mm2s_tvalid),
        .mm2s_beat       (mm2s_beat),
        .mm2s_tready     (mm2s_tready),
        .s2mm_tvalid     (s2mm_tvalid),
        .s2mm_beat       (s2mm_beat),
        .s2mm_tready     (s2mm_tready),
        .img_out_tvalid  (img_out_tvalid),
        .img_out_beat    (img_out_beat),
        .img_out_tready  (img_out_tready),
        .img_in_tvalid   (img_in_tvalid),
        .img_in_beat     (img_in_beat),
        .img_in_tready   (img_in_tready),
        .math_out_tvalid (math_out_tvalid),
        .math_out_beat   (math_out_beat),
        .math_out_tready (math_out_tready),
        .math_in_tvalid  (math_in_tvalid),
        .math_in_beat    (math_in_beat),
        .math_in_tready  (math_in_tready),
        .copy_out_tvalid (copy_out_tvalid),
        .copy_out_beat   (copy_out_beat),
        .copy_out_tready (copy_out_tready),
        .copy_in_tvalid  (copy_in_tvalid),
        .copy_in_beat    (copy_in_beat),
        .copy_in_tready  (copy_in_tready)
    );

    status_stream_gen u_status (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .sts_load   (sts_load),
        .sts_count  (sts_count),
        .fun        (fun),
        .sts_tvalid (sts_tvalid),
        .sts_beat   (sts_beat),
        .sts_tready (sts_tready),
        .sts_busy   (sts_busy)
    );

endmodule

`default_nettype wire

//--- bench/tb_pipe_sel.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module tb_pipe_sel
    import pipe_pkg::*;
;

    localparam int MAX_CYCLES = 4000;

    logic                    aclk;
    logic                    arst_n;
    logic                    ctrl_tvalid;
    logic [`PIPE_CTRL_W-1:0] ctrl_tdata;
    logic                    ctrl_tlast;
    logic                    ctrl_tready;
    logic                    mm2s_tvalid;
    axis_beat_t              mm2s_beat;
    logic                    mm2s_tready;
    logic                    s2mm_tvalid;
    axis_beat_t              s2mm_beat;
    logic                    s2mm_tready;
    // channel index 0 image, 1 math, 2 copy
    logic [2:0]              ch_out_tvalid;
    axis_beat_t              ch_out_beat [3];
    logic [2:0]              ch_out_tready;
    logic [2:0]              ch_in_tvalid;
    axis_beat_t              ch_in_beat [3];
    logic [2:0]              ch_in_tready;
    logic                    sts_tvalid;
    sts_beat_t               sts_beat;
    logic                    sts_tready;
    app_words_t              app_words;
    edge_cfg_t               edge_cfg;
    logic                    vsync;

    int          cycle_cnt;
    logic [31:0] rng_state;
    logic [31:0] sts_rng;
    logic        sts_rand_en;
    string       ch_name [3] = '{"img", "math", "copy"};

    // reference model state
    logic        m_wait;
    int          m_widx;
    logic [7:0]  m_cnt;
    logic [31:0] m_shadow [`PIPE_APP_WORDS];
    logic [31:0] m_active [`PIPE_APP_WORDS];
    logic        m_vsync;
    logic        m_sts_valid;
    logic [7:0]  m_sts_cnt;

    pipe_sel i_dut (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .ctrl_tvalid     (ctrl_tvalid),
        .ctrl_tdata      (ctrl_tdata),
        .ctrl_tlast      (ctrl_tlast),
        .ctrl_tready     (ctrl_tready),
        .mm2s_tvalid     (mm2s_tvalid),
        .mm2s_beat       (mm2s_beat),
        .mm2s_tready     (mm2s_tready),
        .s2mm_tvalid     (s2mm_tvalid),
        .s2mm_beat       (s2mm_beat),
        .s2mm_tready     (s2mm_tready),
        .img_out_tvalid  (ch_out_tvalid[0]),
        .img_out_beat    (ch_out_beat[0]),
        .img_out_tready  (ch_out_tready[0]),
        .img_in_tvalid   (ch_in_tvalid[0]),
        .img_in_beat     (ch_in_beat[0]),
        .img_in_tready   (ch_in_tready[0]),
        .math_out_tvalid (ch_out_tvalid[1]),
        .math_out_beat   (ch_out_beat[1]),
        .math_out_tready (ch_out_tready[1]),
        .math_in_tvalid  (ch_in_tvalid[1]),
        .math_in_beat    (ch_in_beat[1]),
        .math_in_tready  (ch_in_tready[1]),
        .copy_out_tvalid (ch_out_tvalid[2]),
        .copy_out_beat   (ch_out_beat[2]),
        .copy_out_tready (ch_out_tready[2]),
        .copy_in_tvalid  (ch_in_tvalid[2]),
        .copy_in_beat    (ch_in_beat[2]),
        .copy_in_tready  (ch_in_tready[2]),
        .sts_tvalid      (sts_tvalid),
        .sts_beat        (sts_beat),
        .sts_tready      (sts_tready),
        .app_words       (app_words),
        .edge_cfg        (edge_cfg),
        .vsync           (vsync)
    );

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 0 image, 1 math, 2 copy, anything else selects no channel
    function automatic int route_of(input logic [7:0] code);
        case (code)
            8'd0:    return 0;
            8'd1:    return 1;
            8'd2:    return 2;
            default: return 3;
        endcase
    endfunction

    // edge settings live in word 1 bits 8 to 27
    function automatic edge_cfg_t edge_of(input logic [31:0] w);
        edge_cfg_t e;
        e.canny_max_val     = w[15:8];
        e.canny_min_val     = w[23:16];
        e.sobel_edge_sel    = w[24];
        e.nonmax_supp_en    = w[25];
        e.hyst_threshold_en = w[26];
        e.edge_cut_en       = w[27];
        return e;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic rand_beat(output axis_beat_t b);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        next_rand(r0);
        next_rand(r1);
        next_rand(r2);
        b.tdata = {r0, r1};
        b.tkeep = r2[7:0];
        b.tlast = r2[8];
    endtask

    task automatic check_value(input string name, input logic [191:0] got,
                               input logic [191:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    task automatic reset_model();
        m_wait      = 1'b1;
        m_widx      = 0;
        m_cnt       = '0;
        m_vsync     = 1'b0;
        m_sts_valid = 1'b0;
        m_sts_cnt   = '0;
        for (int i = 0; i < `PIPE_APP_WORDS; i++)
        begin
            m_shadow[i] = '0;
            m_active[i] = '0;
        end
    endtask

    task automatic check_outputs();
        int         sel;
        sts_beat_t  exp_sts;
        axis_beat_t exp_beat;
        sel = route_of(m_active[0][7:0]);
        check_value("ctrl_tready", ctrl_tready, !m_wait);
        check_value("vsync", vsync, m_vsync);
        for (int i = 0; i < `PIPE_APP_WORDS; i++)
            check_value($sformatf("app_words[%0d]", i), app_words[i], m_active[i]);
        check_value("edge_cfg", edge_cfg, edge_of(m_active[1]));
        check_value("sts_tvalid", sts_tvalid, m_sts_valid);
        if (m_sts_valid)
        begin
            exp_sts.tdata        = '0;
            exp_sts.tdata[7:0]   = m_active[0][7:0];
            exp_sts.tdata[15:8]  = m_sts_cnt;
            exp_sts.tdata[16]    = (m_sts_cnt != 8'd5);
            exp_sts.tkeep        = '1;
            exp_sts.tlast        = 1'b1;
            check_value("sts_beat", sts_beat, exp_sts);
        end
        for (int ch = 0; ch < 3; ch++)
        begin
            exp_beat = (ch == sel) ? mm2s_beat : axis_beat_t'(0);
            check_value({ch_name[ch], "_out_tvalid"}, ch_out_tvalid[ch],
                        (ch == sel) ? mm2s_tvalid : 1'b0);
            check_value({ch_name[ch], "_out_beat"}, ch_out_beat[ch], exp_beat);
            check_value({ch_name[ch], "_in_tready"}, ch_in_tready[ch],
                        (ch == sel) ? s2mm_tready : 1'b0);
        end
        exp_beat = (sel < 3) ? ch_in_beat[sel] : axis_beat_t'(0);
        check_value("mm2s_tready", mm2s_tready, (sel < 3) ? ch_out_tready[sel] : 1'b0);
        check_value("s2mm_tvalid", s2mm_tvalid, (sel < 3) ? ch_in_tvalid[sel] : 1'b0);
        check_value("s2mm_beat", s2mm_beat, exp_beat);
    endtask

    // state after the coming edge, from the inputs held during this cycle
    task automatic advance_model();
        logic beat_ok;
        logic last_ok;
        beat_ok = ctrl_tvalid && !m_wait;
        last_ok = beat_ok && ctrl_tlast;
        if (beat_ok && m_widx < `PIPE_APP_WORDS)
            m_shadow[m_widx] = ctrl_tdata;
        m_vsync = last_ok;
        if (m_wait)
        begin
            if (!m_sts_valid)
                m_wait = 1'b0;
        end
        else if (last_ok)
        begin
            m_wait      = 1'b1;
            m_active    = m_shadow;
            m_sts_valid = 1'b1;
            m_sts_cnt   = m_cnt + 8'd1;
            m_widx      = 0;
            m_cnt       = '0;
        end
        else if (beat_ok)
        begin
            if (m_widx < `PIPE_APP_WORDS)
                m_widx++;
            m_cnt = m_cnt + 8'd1;
        end
        if (!last_ok && sts_tready)
            m_sts_valid = 1'b0;
    endtask

    always @(negedge aclk)
    begin
        if (!arst_n)
            reset_model();
        else
        begin
            check_outputs();
            advance_model();
        end
    end

    always @(posedge aclk)
    begin
        sts_rng = xorshift32(sts_rng);
        sts_tready <= sts_rand_en ? sts_rng[0] : 1'b1;
    end

    always @(posedge aclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic send_ctrl_packet(input int n_words, input logic [7:0] code,
                                    input bit check_words);
        logic [31:0] words [8];
        logic [31:0] r;
        for (int i = 0; i < n_words; i++)
        begin
            next_rand(r);
            words[i] = r;
        end
        words[0][7:0] = code;
        for (int i = 0; i < n_words; i++)
        begin
            next_rand(r);
            // occasional idle cycle
            if (r[2:0] == 3'd0)
            begin
                @(posedge aclk);
                ctrl_tvalid <= 1'b0;
            end
            @(posedge aclk);
            ctrl_tvalid <= 1'b1;
            ctrl_tdata  <= words[i];
            ctrl_tlast  <= (i == n_words - 1);
            @(negedge aclk);
            while (!ctrl_tready)
                @(negedge aclk);
        end
        @(posedge aclk);
        ctrl_tvalid <= 1'b0;
        ctrl_tlast  <= 1'b0;
        @(negedge aclk);
        check_value("vsync", vsync, 1'b1);
        if (check_words)
        begin
            for (int i = 0; i < `PIPE_APP_WORDS; i++)
                check_value($sformatf("app_words[%0d]", i), app_words[i], words[i]);
            check_value("edge_cfg", edge_cfg, edge_of(words[1]));
        end
        @(negedge aclk);
        check_value("vsync", vsync, 1'b0);
    endtask

    task automatic wait_drained();
        @(negedge aclk);
        while (sts_tvalid || !ctrl_tready)
            @(negedge aclk);
    endtask

    task automatic run_traffic(input int n_cycles);
        logic [31:0] r;
        axis_beat_t  b;
        for (int c = 0; c < n_cycles; c++)
        begin
            @(posedge aclk);
            next_rand(r);
            mm2s_tvalid   <= r[0];
            s2mm_tready   <= r[1];
            ch_out_tready <= r[4:2];
            ch_in_tvalid  <= r[7:5];
            rand_beat(b);
            mm2s_beat <= b;
            for (int ch = 0; ch < 3; ch++)
            begin
                rand_beat(b);
                ch_in_beat[ch] <= b;
            end
        end
        @(posedge aclk);
        mm2s_tvalid   <= 1'b0;
        s2mm_tready   <= 1'b0;
        ch_out_tready <= '0;
        ch_in_tvalid  <= '0;
    endtask

    initial
    begin
        logic [31:0] r;
        logic [7:0]  codes [5];
        cycle_cnt   = 0;
        rng_state   = 32'hc3f3745d;
        sts_rng     = xorshift32(32'hc3f3745d);
        sts_rand_en = 1'b0;
        arst_n      = 1'b0;
        ctrl_tvalid = 1'b0;
        ctrl_tdata  = '0;
        ctrl_tlast  = 1'b0;
        mm2s_tvalid = 1'b0;
        mm2s_beat   = '0;
        s2mm_tready = 1'b0;
        sts_tready  = 1'b0;
        ch_out_tready = '0;
        ch_in_tvalid  = '0;
        for (int ch = 0; ch < 3; ch++)
            ch_in_beat[ch] = '0;
        codes = '{FUN_IMAGE, FUN_MATH, FUN_COPY, 8'h5a, 8'ha7};

        repeat (4) @(posedge aclk);
        arst_n <= 1'b1;
        @(negedge aclk);
        check_value("ctrl_tready", ctrl_tready, 1'b0);
        check_value("vsync", vsync, 1'b0);
        check_value("sts_tvalid", sts_tvalid, 1'b0);
        check_value("app_words", app_words, '0);
        @(negedge aclk);
        check_value("ctrl_tready", ctrl_tready, 1'b1);

        // each function code, then two codes outside the defined set
        for (int i = 0; i < 5; i++)
        begin
            send_ctrl_packet(5, codes[i], 1'b1);
            wait_drained();
            run_traffic((i < 3) ? 200 : 100);
        end

        // short, full and long packets against a stalling status sink
        wait_drained();
        sts_rand_en = 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            next_rand(r);
            send_ctrl_packet(3 + 2 * (i % 3), 8'(r % 3), (i % 3) == 1);
        end
        wait_drained();
        sts_rand_en = 1'b0;
        @(posedge aclk);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+rtl
rtl/pipe_pkg.sv
rtl/ctrl_word_capture.sv
rtl/stream_switch.sv
rtl/status_stream_gen.sv
rtl/pipe_sel.sv
bench/tb_pipe_sel.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_sel
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
